//--- acq_event_fifo.sv
// first-word-fall-through event fifo with occupancy count
`timescale 1ns/1ps

module acq_event_fifo #(
  parameter int fifo_depth = 16
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               wr_valid,
  input  logic [acq_pkg::event_w-1:0]        wr_data,
  output logic                               wr_ready,  // not full
  input  logic                               rd,        // pop strobe
  output logic [acq_pkg::event_w-1:0]        rd_data,   // head word
  output logic                               empty,
  output logic [$clog2(fifo_depth+1)-1:0]    count
);

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w = $clog2(fifo_depth + 1);

  logic [acq_pkg::event_w-1:0] mem [fifo_depth];
  logic [ptr_w-1:0]            wr_ptr;
  logic [ptr_w-1:0]            rd_ptr;
  logic                        do_wr;
  logic                        do_rd;

  assign empty    = (count == '0);
  assign wr_ready = (count != cnt_w'(fifo_depth));
  assign do_wr    = wr_valid & wr_ready;
  assign do_rd    = rd & ~empty;  // read on empty ignored

  assign rd_data = mem[rd_ptr];  // head falls through

  // wrap at depth, so non power-of-two also works
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(fifo_depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

//--- acq_pkg.sv
// shared widths, channel count, one-hot state indices and event word layout
package acq_pkg;

  // digitizer crate geometry
  localparam int num_chan = 5;

  // field widths
  localparam int trig_type_w = 5;   // ttc trigger type code
  localparam int trig_num_w  = 24;  // running trigger number
  localparam int delay_w     = 32;  // programmable trigger delay
  localparam int event_w     = 32;  // event information word
  localparam int lost_w      = 16;  // saturating lost trigger counter

  // one-hot state bit positions of the acquisition controller
  localparam int st_idle  = 0;
  localparam int st_delay = 1;
  localparam int st_fill  = 2;
  localparam int st_store = 3;
  localparam int num_states = 4;

  // event word from msb down holds 3 zero bits, type and number
  localparam int evt_num_lsb  = 0;
  localparam int evt_type_lsb = evt_num_lsb + trig_num_w;  // bit 24

endpackage

//--- acq_trigger_checker.sv
// bound controller assertions for one-hot state, held fifo word and channel trigger mask
`timescale 1ns/1ps

module acq_trigger_checker (
  input logic                           clk,
  input logic                           reset,
  input logic [acq_pkg::num_states-1:0] state,
  input logic                           fifo_valid,
  input logic                           fifo_ready,
  input logic [acq_pkg::event_w-1:0]    fifo_data,
  input logic [acq_pkg::num_chan-1:0]   acq_trig,
  input logic [acq_pkg::num_chan-1:0]   chan_en
);

  int fail_count = 0;  // failed assertions so far

  // exactly one state bit at every edge
  state_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(state))
    else begin
      $error("controller state not one-hot: %b", state);
      fail_count++;
    end

  // a refused word stays offered from store and unchanged
  valid_in_store: assert property (@(posedge clk) disable iff (reset)
    fifo_valid && !fifo_ready |=> fifo_valid && state[acq_pkg::st_store] && $stable(fifo_data))
    else begin
      $error("event word not held in store after the fifo refused it, state %b", state);
      fail_count++;
    end

  // disabled channels never get a trigger
  trig_in_mask: assert property (@(posedge clk) disable iff (reset)
    (acq_trig & ~chan_en) == '0)
    else begin
      $error("acq_trig %b outside chan_en %b", acq_trig, chan_en);
      fail_count++;
    end

endmodule

bind channel_acq_controller_cbuf acq_trigger_checker u_checker (
  .clk        (clk),
  .reset      (reset),
  .state      (state),
  .fifo_valid (fifo_valid),
  .fifo_ready (fifo_ready),
  .fifo_data  (fifo_data),
  .acq_trig   (acq_trig),
  .chan_en    (chan_en)
);

//--- acq_trigger_top.sv
// trigger acquisition subsystem top: front end, acquisition controller, event fifo
`timescale 1ns/1ps

module acq_trigger_top #(
  parameter int fifo_depth = 16
) (
  input  logic                            clk,
  input  logic                            reset,

  // ttc side
  input  logic                            trigger,
  input  logic [acq_pkg::trig_type_w-1:0] trig_type,

  // configuration
  input  logic [acq_pkg::num_chan-1:0]    chan_en,
  input  logic [acq_pkg::delay_w-1:0]     trig_delay,
  input  logic                            async_mode,
  input  logic                            cbuf_mode,

  // channels
  input  logic [acq_pkg::num_chan-1:0]    acq_dones,
  output logic                            acq_ready,
  output logic [acq_pkg::num_chan-1:0]    acq_trig,
  output logic [2*acq_pkg::num_chan-1:0]  acq_enable,

  // status
  output logic [acq_pkg::num_states-1:0]  state,
  output logic [acq_pkg::trig_num_w-1:0]  trig_count,
  output logic [acq_pkg::lost_w-1:0]      lost_count,

  // readout port
  input  logic                            evt_rd,
  output logic [acq_pkg::event_w-1:0]     evt_data,
  output logic                            evt_empty,
  output logic [$clog2(fifo_depth+1)-1:0] evt_count
);

  // front end to controller
  logic                            acc_trig;
  logic [acq_pkg::trig_type_w-1:0] acc_type;
  logic [acq_pkg::trig_num_w-1:0]  acc_num;

  // controller to fifo
  logic                            fifo_valid;
  logic                            fifo_ready;
  logic [acq_pkg::event_w-1:0]     fifo_data;

  ttc_trigger_frontend u_frontend (
    .clk        (clk),
    .reset      (reset),
    .trigger    (trigger),
    .trig_type  (trig_type),
    .acq_ready  (acq_ready),
    .async_mode (async_mode),
    .cbuf_mode  (cbuf_mode),
    .acc_trig   (acc_trig),
    .acc_type   (acc_type),
    .acc_num    (acc_num),
    .trig_count (trig_count),
    .lost_count (lost_count)
  );

  channel_acq_controller_cbuf u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .chan_en    (chan_en),
    .trig_delay (trig_delay),
    .acc_trig   (acc_trig),
    .acc_type   (acc_type),
    .acc_num    (acc_num),
    .acq_ready  (acq_ready),
    .acq_dones  (acq_dones),
    .acq_enable (acq_enable),
    .acq_trig   (acq_trig),
    .fifo_ready (fifo_ready),
    .fifo_valid (fifo_valid),
    .fifo_data  (fifo_data),
    .state      (state)
  );

  acq_event_fifo #(
    .fifo_depth (fifo_depth)
  ) u_fifo (
    .clk      (clk),
    .reset    (reset),
    .wr_valid (fifo_valid),
    .wr_data  (fifo_data),
    .wr_ready (fifo_ready),
    .rd       (evt_rd),
    .rd_data  (evt_data),
    .empty    (evt_empty),
    .count    (evt_count)
  );

endmodule

//--- channel_acq_controller_cbuf.sv
// circular buffer acquisition controller: delay, channel trigger, done collection, event store
`timescale 1ns/1ps

module channel_acq_controller_cbuf (
  input  logic                            clk,
  input  logic                            reset,

  // configuration
  input  logic [acq_pkg::num_chan-1:0]    chan_en,     // channels taking part
  input  logic [acq_pkg::delay_w-1:0]     trig_delay,  // cycles between accept and fill

  // accepted trigger from the front end
  input  logic                            acc_trig,
  input  logic [acq_pkg::trig_type_w-1:0] acc_type,
  input  logic [acq_pkg::trig_num_w-1:0]  acc_num,
  output logic                            acq_ready,

  // channel fpga lines
  input  logic [acq_pkg::num_chan-1:0]    acq_dones,
  output logic [2*acq_pkg::num_chan-1:0]  acq_enable,  // two bits per channel
  output logic [acq_pkg::num_chan-1:0]    acq_trig,

  // event fifo write side
  input  logic                            fifo_ready,
  output logic                            fifo_valid,
  output logic [acq_pkg::event_w-1:0]     fifo_data,

  // status
  output logic [acq_pkg::num_states-1:0]  state         // one-hot
);

  logic [acq_pkg::num_states-1:0]  nextstate;
  logic [acq_pkg::trig_type_w-1:0] type_q;      // latched at acceptance
  logic [acq_pkg::trig_num_w-1:0]  num_q;
  logic [acq_pkg::num_chan-1:0]    next_acq_trig;
  logic [acq_pkg::delay_w-1:0]     delay_cnt;
  logic                            delay_done;
  logic                            all_done;

  // last delay cycle when the count reaches trig_delay - 1
  assign delay_done = (delay_cnt == trig_delay - 1'b1);

  // every enabled channel has reported back
  assign all_done = (acq_dones == chan_en);

  // circular buffers keep filling while the type is nonzero
  assign acq_enable = {acq_pkg::num_chan{type_q[1:0]}};

  assign acq_ready = state[acq_pkg::st_idle];

  // event word is static while in store
  always_comb begin
    fifo_data = '0;                                                // top 3 bits stay zero
    fifo_data[acq_pkg::evt_type_lsb +: acq_pkg::trig_type_w] = type_q;
    fifo_data[acq_pkg::evt_num_lsb  +: acq_pkg::trig_num_w]  = num_q;
  end

  // next state and channel trigger
  always_comb begin
    nextstate     = '0;
    next_acq_trig = '0;

    case (1'b1)
      state[acq_pkg::st_idle]: begin
        if (acc_trig) begin  // mode gating already done upstream
          if (trig_delay != '0) begin
            nextstate[acq_pkg::st_delay] = 1'b1;
          end else begin
            nextstate[acq_pkg::st_fill] = 1'b1;
          end
        end else begin
          nextstate[acq_pkg::st_idle] = 1'b1;
        end
      end

      state[acq_pkg::st_delay]: begin
        if (delay_done) begin
          nextstate[acq_pkg::st_fill] = 1'b1;
        end else begin
          nextstate[acq_pkg::st_delay] = 1'b1;
        end
      end

      // hold trigger on enabled channels until all are done
      state[acq_pkg::st_fill]: begin
        next_acq_trig = chan_en;
        if (all_done) begin
          nextstate[acq_pkg::st_store] = 1'b1;
        end else begin
          nextstate[acq_pkg::st_fill] = 1'b1;
        end
      end

      // wait here while the fifo is full
      state[acq_pkg::st_store]: begin
        if (fifo_ready) begin
          nextstate[acq_pkg::st_idle] = 1'b1;
        end else begin
          nextstate[acq_pkg::st_store] = 1'b1;
        end
      end

      default: begin
        nextstate[acq_pkg::st_idle] = 1'b1;  // recover from a corrupt state
      end
    endcase
  end

  // control registers
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= '0;
      state[acq_pkg::st_idle] <= 1'b1;
      type_q     <= '0;  // clears acq_enable
      acq_trig   <= '0;
      fifo_valid <= 1'b0;
    end else begin
      state      <= nextstate;
      acq_trig   <= next_acq_trig;                 // one cycle behind fill
      fifo_valid <= nextstate[acq_pkg::st_store];  // high for every store cycle
      if (state[acq_pkg::st_idle] && acc_trig) begin
        type_q <= acc_type;
      end
    end
  end

  // trigger number latch
  always_ff @(posedge clk) begin
    if (state[acq_pkg::st_idle] && acc_trig) begin
      num_q <= acc_num;
    end
  end

  // delay counter restarts on acceptance, runs only in delay
  always_ff @(posedge clk) begin
    if (reset || acc_trig) begin
      delay_cnt <= '0;
    end else if (state[acq_pkg::st_delay]) begin
      delay_cnt <= delay_cnt + 1'b1;
    end
  end

endmodule

//--- src.f
acq_pkg.sv
ttc_trigger_frontend.sv
channel_acq_controller_cbuf.sv
acq_event_fifo.sv
acq_trigger_top.sv
acq_trigger_checker.sv
tb_acq_trigger_top.sv

//--- tb_acq_trigger_top.sv
// testbench for the trigger acquisition top with clock, reset, channel done model and tests
`timescale 1ns/1ps

module tb_acq_trigger_top;

  localparam int depth = 8;  // small event fifo that fills quickly
  localparam int nc    = acq_pkg::num_chan;

  logic                            clk = 1'b0;
  logic                            reset = 1'b1;
  logic                            trigger = 1'b0;
  logic                            async_mode = 1'b0;
  logic                            cbuf_mode = 1'b1;
  logic                            evt_rd = 1'b0;
  logic [acq_pkg::trig_type_w-1:0] trig_type = '0;
  logic [nc-1:0]                   chan_en = '0;
  logic [acq_pkg::delay_w-1:0]     trig_delay = '0;
  logic [nc-1:0]                   acq_dones = '0;   // driven by the channel model
  logic                            acq_ready;
  logic                            evt_empty;
  logic [nc-1:0]                   acq_trig;
  logic [2*nc-1:0]                 acq_enable;
  logic [acq_pkg::num_states-1:0]  state;
  logic [acq_pkg::trig_num_w-1:0]  trig_count;
  logic [acq_pkg::lost_w-1:0]      lost_count;
  logic [acq_pkg::event_w-1:0]     evt_data;
  logic [$clog2(depth+1)-1:0]      evt_count;

  integer seed = 32'h3216_1e14;
  int done_dly [nc];                       // done latency per channel, cycles
  int done_cnt [nc];
  logic [acq_pkg::event_w-1:0] exp_q [$];  // expected readout words, oldest first
  int next_num = 0;                        // number of the next accepted trigger
  int checks = 0;
  int errors = 0;

  always #10 clk = ~clk;

  acq_trigger_top #(.fifo_depth(depth)) UUT (.*);

  // channel fpgas raise done after their delay and drop it with acq_trig
  always @(posedge clk) begin
    #2;
    for (int i = 0; i < nc; i++) begin
      if (!acq_trig[i]) begin
        acq_dones[i] = 1'b0;
        done_cnt[i]  = 0;
      end else if (!acq_dones[i]) begin
        done_cnt[i]++;
        if (done_cnt[i] >= done_dly[i]) begin
          acq_dones[i] = 1'b1;
        end
      end
    end
  end

  // 3 zero bits, type, number
  function automatic logic [acq_pkg::event_w-1:0] event_word(
    input logic [acq_pkg::trig_type_w-1:0] t, input int n);
    logic [acq_pkg::event_w-1:0] w;
    w = t;
    w = w << acq_pkg::evt_type_lsb;
    w = w | (n[acq_pkg::trig_num_w-1:0] << acq_pkg::evt_num_lsb);
    return w;
  endfunction

  task automatic tick();
    @(posedge clk);
    #2;  // sample and drive point
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("at %0t ns: %s", $time, what);
    end
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (10) tick();
    reset = 1'b0;
    exp_q.delete();
    next_num = 0;
  endtask

  // 0 draws 1 to 8 cycles per channel
  task automatic set_done_delays(input int fixed);
    for (int i = 0; i < nc; i++) begin
      done_dly[i] = (fixed > 0) ? fixed : 1 + ({$random(seed)} % 8);
    end
  endtask

  task automatic send_trigger(input logic [acq_pkg::trig_type_w-1:0] t, input int d);
    trig_delay = d;
    trig_type  = t;
    trigger    = 1'b1;
    tick();
    trigger    = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!state[acq_pkg::st_idle] && n < 200) begin
      tick();
      n++;
    end
    check_true(state[acq_pkg::st_idle], "controller did not return to idle in time");
  endtask

  // one accepted trigger up to store entry
  task automatic run_event(input logic [acq_pkg::trig_type_w-1:0] t, input int d);
    int n;
    int maxd;
    logic [2*nc-1:0] exp_en;
    maxd = 0;
    for (int i = 0; i < nc; i++) begin
      exp_en[2*i +: 2] = t[1:0];  // low type bits on every pair
      if (chan_en[i] && done_dly[i] > maxd) begin
        maxd = done_dly[i];
      end
    end
    send_trigger(t, d);
    n = 1;
    while (acq_trig == '0 && n < d + 50) begin
      tick();
      n++;
    end
    check_true(acq_trig != '0, "acq_trig never rose after the trigger");
    check_value("acq_trig latency", n, d + 3);  // frontend, delay, fill entry, register
    check_value("acq_trig", acq_trig, chan_en);
    check_value("acq_enable", acq_enable, exp_en);
    n = 1;
    while (state[acq_pkg::st_fill] && n < 50) begin
      check_value("acq_trig & ~chan_en", acq_trig & ~chan_en, 0);
      tick();
      n++;
    end
    check_value("fill cycles", n, maxd + 1);  // slowest done plus the store edge
    check_true(state[acq_pkg::st_store], "controller did not go from fill to store");
    exp_q.push_back(event_word(t, next_num));
    next_num++;
  endtask

  task automatic read_event();
    logic [acq_pkg::event_w-1:0] exp;
    exp = exp_q.pop_front();
    check_value("evt_empty", evt_empty, 0);
    check_value("evt_data", evt_data, exp);
    evt_rd = 1'b1;
    tick();
    evt_rd = 1'b0;
  endtask

  task automatic drain_all();
    while (exp_q.size() > 0) begin
      read_event();
    end
    check_value("evt_empty", evt_empty, 1);
  endtask

  task automatic test_done(input string name, input int e0);
    $display("%-20s finished with %0d errors", name, errors - e0);
  endtask

  task automatic test_zero_delay();
    int e0;
    e0 = errors;
    chan_en = '1;
    set_done_delays(0);
    run_event(5'h16, 0);
    wait_idle();
    check_value("trig_count", trig_count, 1);
    check_value("evt_data number", evt_data[acq_pkg::evt_num_lsb +: acq_pkg::trig_num_w], 0);
    check_value("evt_data type", evt_data[acq_pkg::evt_type_lsb +: acq_pkg::trig_type_w], 5'h16);
    drain_all();
    test_done("zero delay", e0);
  endtask

  task automatic test_delays();
    int e0;
    e0 = errors;
    set_done_delays(0);
    run_event(5'h0d, 3);
    wait_idle();
    run_event(5'h12, 17);
    wait_idle();
    drain_all();
    test_done("programmed delay", e0);
  endtask

  task automatic test_partial();
    int e0;
    e0 = errors;
    chan_en = 5'b10110;  // channels 1, 2, 4
    for (int k = 0; k < 4; k++) begin
      set_done_delays(0);
      run_event(5'(k + 9), k);
      wait_idle();
    end
    check_value("trig_count", trig_count, next_num);
    drain_all();  // numbers step by one
    chan_en = '1;
    test_done("partial enable", e0);
  endtask

  task automatic test_lost();
    int e0;
    int lost0;
    int trig0;
    e0 = errors;
    lost0 = lost_count;
    trig0 = trig_count;
    set_done_delays(8);
    send_trigger(5'h03, 10);
    exp_q.push_back(event_word(5'h03, next_num));
    next_num++;
    tick();
    tick();  // controller now in delay
    send_trigger(5'h04, 10);
    tick();
    send_trigger(5'h05, 10);
    tick();
    check_value("lost_count", lost_count, lost0 + 2);
    wait_idle();
    check_value("trig_count", trig_count, trig0 + 1);
    drain_all();  // only the first trigger made an event
    async_mode = 1'b1;
    send_trigger(5'h06, 0);
    async_mode = 1'b0;
    cbuf_mode  = 1'b0;
    send_trigger(5'h07, 0);
    cbuf_mode  = 1'b1;
    repeat (4) begin
      tick();
      check_true(acq_ready, "mode blocked trigger started an acquisition");
    end
    check_value("trig_count", trig_count, trig0 + 1);
    check_value("lost_count", lost_count, lost0 + 2);
    check_value("evt_empty", evt_empty, 1);
    test_done("lost and blocked", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0 = errors;
    set_done_delays(2);
    for (int k = 0; k < depth; k++) begin
      run_event(5'(k + 1), 0);
      wait_idle();
    end
    check_value("evt_count", evt_count, depth);
    run_event(5'h1f, 0);
    repeat (5) begin
      tick();
      check_true(state[acq_pkg::st_store] && !acq_ready, "controller left store with fifo full");
    end
    read_event();  // frees one slot for the held word
    wait_idle();
    check_value("evt_count", evt_count, depth);
    drain_all();
    evt_rd = 1'b1;  // read on empty
    tick();
    evt_rd = 1'b0;
    check_value("evt_count", evt_count, 0);
    test_done("back-pressure", e0);
  endtask

  task automatic test_mid_reset();
    int e0;
    int n;
    e0 = errors;
    set_done_delays(8);
    run_event(5'h02, 0);
    wait_idle();  // leave one word in the fifo
    send_trigger(5'h0a, 0);
    n = 0;
    while (acq_trig == '0 && n < 20) begin
      tick();
      n++;
    end
    check_true(acq_trig != '0, "acq_trig never rose before the reset");
    apply_reset();
    check_value("state", state, 1 << acq_pkg::st_idle);
    check_value("acq_trig", acq_trig, 0);
    check_value("acq_enable", acq_enable, 0);
    check_value("fifo_valid", UUT.u_ctrl.fifo_valid, 0);
    check_value("trig_count", trig_count, 0);
    check_value("lost_count", lost_count, 0);
    check_value("evt_count", evt_count, 0);
    check_value("evt_empty", evt_empty, 1);
    test_done("reset mid-acquisition", e0);
  endtask

  initial begin
    set_done_delays(1);
    apply_reset();
    test_zero_delay();
    test_delays();
    test_partial();
    test_lost();
    test_backpressure();
    test_mid_reset();
    errors += UUT.u_ctrl.u_checker.fail_count;  // bound assertion failures
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- ttc_trigger_frontend.sv
// trigger front end: readiness and mode gate, trigger numbering, lost trigger count
`timescale 1ns/1ps

module ttc_trigger_frontend (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           trigger,     // single cycle strobe from ttc rx
  input  logic [acq_pkg::trig_type_w-1:0] trig_type,
  input  logic                           acq_ready,   // controller idle
  input  logic                           async_mode,
  input  logic                           cbuf_mode,
  output logic                           acc_trig,    // accepted strobe, one cycle
  output logic [acq_pkg::trig_type_w-1:0] acc_type,
  output logic [acq_pkg::trig_num_w-1:0]  acc_num,
  output logic [acq_pkg::trig_num_w-1:0]  trig_count,
  output logic [acq_pkg::lost_w-1:0]      lost_count
);

  logic mode_ok;    // circular buffer mode and not async readout
  logic busy;       // controller cannot take a new trigger
  logic accept;
  logic lost;

  assign mode_ok = cbuf_mode & ~async_mode;

  // acq_ready is still high in the cycle acc_trig is out,
  // so a strobe already in flight also counts as busy
  assign busy   = ~acq_ready | acc_trig;
  assign accept = trigger & mode_ok & ~busy;
  assign lost   = trigger & mode_ok & busy;

  // strobe and counters
  always_ff @(posedge clk) begin
    if (reset) begin
      acc_trig   <= 1'b0;
      trig_count <= '0;
      lost_count <= '0;
    end else begin
      acc_trig <= accept;
      if (accept) begin
        trig_count <= trig_count + 1'b1;  // number of next trigger
      end
      if (lost && (lost_count != {acquire_lost_max()})) begin
        lost_count <= lost_count + 1'b1;  // saturates at all ones
      end
    end
  end

  // payload travels with the strobe
  always_ff @(posedge clk) begin
    if (accept) begin
      acc_type <= trig_type;
      acc_num  <= trig_count;  // first trigger after reset is number 0
    end
  end

  // all ones value of the lost counter
  function automatic logic [acq_pkg::lost_w-1:0] acquire_lost_max();
    return '1;
  endfunction

endmodule
